// ==== sources.f ====
+incdir+src
src/conv_window_pkg.sv
src/line_buffer.sv
src/window_array.sv
src/window_valid_ctrl.sv
src/conv_7x7_window.sv
testbench/tb_clock_gen.sv
testbench/conv_7x7_window_checker.sv
testbench/tb_conv_7x7_window.sv

// ==== src/conv_7x7_window.sv ====
`timescale 1ns/1ps

module conv_7x7_window (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     valid_in,
	input  conv_window_pkg::pixel_t  pixel_in,
	output conv_window_pkg::window_t pxl_window,
	output logic                     valid_out,
	output logic                     load_weights
);

	import conv_window_pkg::*;

	// Loads the window bank and starts the output pulse
	logic capture;

	////////////////////////////////////////////////////////////////////////////
	// Datapath

	window_array u_window_array (
		.clk        (clk        ),
		.reset      (reset      ),
		.valid_in   (valid_in   ),
		.pixel_in   (pixel_in   ),
		.capture    (capture    ),
		.pxl_window (pxl_window )
	);

	////////////////////////////////////////////////////////////////////////////
	// Control

	window_valid_ctrl u_window_valid_ctrl (
		.clk          (clk          ),
		.reset        (reset        ),
		.valid_in     (valid_in     ),
		.capture      (capture      ),
		.valid_out    (valid_out    ),
		.load_weights (load_weights )
	);

endmodule

// ==== src/conv_window_defines.svh ====
`ifndef CONV_WINDOW_DEFINES_SVH
`define CONV_WINDOW_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Pixel format

`define CONV_DATA_WIDTH   32

////////////////////////////////////////////////////////////////////////////
// Kernel and image geometry

`define CONV_KERNEL       7
`define CONV_IMAGE_WIDTH  12
`define CONV_IMAGE_HEIGHT 12

// Window step in both directions
`define CONV_STRIDE       2

// Pixels between the oldest tap of one row and the newest tap of the row above
`define CONV_LINE_DEPTH   (`CONV_IMAGE_WIDTH - `CONV_KERNEL)

`endif

// ==== src/conv_window_pkg.sv ====
`include "conv_window_defines.svh"

package conv_window_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data types

	typedef logic [`CONV_DATA_WIDTH-1:0] pixel_t;

	// Row index first, then column
	typedef pixel_t [`CONV_KERNEL-1:0][`CONV_KERNEL-1:0] window_t;

	////////////////////////////////////////////////////////////////////////////
	// Position counters and controller state

	// Wide enough for 0 to 11
	typedef logic [3:0] col_cnt_t;
	typedef logic [3:0] row_cnt_t;

	typedef enum logic {
		WAIT_FIRST,
		STREAMING
	} ctrl_state_t;

endpackage

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps
`include "conv_window_defines.svh"

module line_buffer (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    shift_en,
	input  conv_window_pkg::pixel_t data_in,
	output conv_window_pkg::pixel_t data_out
);

	import conv_window_pkg::*;

	// Stage 0 is the entry, last stage drives the row above
	pixel_t chain [`CONV_LINE_DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CONV_LINE_DEPTH; i++) begin
				chain[i] <= '0;
			end
		end else if (shift_en) begin
			chain[0] <= data_in;
			for (int i = 1; i < `CONV_LINE_DEPTH; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	assign data_out = chain[`CONV_LINE_DEPTH-1];

endmodule

// ==== src/window_array.sv ====
`timescale 1ns/1ps
`include "conv_window_defines.svh"

module window_array (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     valid_in,
	input  conv_window_pkg::pixel_t  pixel_in,
	input  logic                     capture,
	output conv_window_pkg::window_t pxl_window
);

	import conv_window_pkg::*;

	logic   valid_q;
	pixel_t pixel_q;

	// taps[i][j] is window row i, column j once a window completes
	pixel_t taps [`CONV_KERNEL][`CONV_KERNEL];

	// Entry of each tap row where the bottom row takes the staged pixel
	pixel_t row_feed [`CONV_KERNEL];

	////////////////////////////////////////////////////////////////////////////
	// Input stage

	// Taps run one cycle behind the accepted stream
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in) begin
			pixel_q <= pixel_in;
		end
	end

	assign row_feed[`CONV_KERNEL-1] = pixel_q;

	////////////////////////////////////////////////////////////////////////////
	// Line buffers between tap rows

	generate
		for (genvar r = 0; r < `CONV_KERNEL - 1; r++) begin : g_line
			line_buffer u_line_buffer (
				.clk      (clk          ),
				.reset    (reset        ),
				.shift_en (valid_q      ),
				.data_in  (taps[r+1][0] ),
				.data_out (row_feed[r]  )
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// Tap shift array

	// Newest pixel enters at bottom right and the oldest leaves at column 0
	always_ff @(posedge clk) begin
		if (valid_q) begin
			for (int r = 0; r < `CONV_KERNEL; r++) begin
				for (int c = 0; c < `CONV_KERNEL - 1; c++) begin
					taps[r][c] <= taps[r][c+1];
				end
				taps[r][`CONV_KERNEL-1] <= row_feed[r];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output window bank

	// Holds until the next capture
	always_ff @(posedge clk) begin
		if (capture) begin
			for (int r = 0; r < `CONV_KERNEL; r++) begin
				for (int c = 0; c < `CONV_KERNEL; c++) begin
					pxl_window[r][c] <= taps[r][c];
				end
			end
		end
	end

endmodule

// ==== src/window_valid_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_window_defines.svh"

module window_valid_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic valid_in,
	output logic capture,
	output logic valid_out,
	output logic load_weights
);

	import conv_window_pkg::*;

	col_cnt_t    col;
	row_cnt_t    row;
	ctrl_state_t state;

	logic last_col;
	logic last_row;
	logic col_aligned;
	logic row_aligned;
	logic window_done;

	////////////////////////////////////////////////////////////////////////////
	// Image position of the next accepted pixel

	assign last_col = (col == col_cnt_t'(`CONV_IMAGE_WIDTH - 1));
	assign last_row = (row == row_cnt_t'(`CONV_IMAGE_HEIGHT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (valid_in) begin
			if (last_col) begin
				col <= '0;
				row <= last_row ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stride selection

	// Pixel is the bottom-right corner of a window on the stride grid
	assign col_aligned = (col >= col_cnt_t'(`CONV_KERNEL - 1)) &&
		(((int'(col) - (`CONV_KERNEL - 1)) % `CONV_STRIDE) == 0);
	assign row_aligned = (row >= row_cnt_t'(`CONV_KERNEL - 1)) &&
		(((int'(row) - (`CONV_KERNEL - 1)) % `CONV_STRIDE) == 0);

	// Pipeline runs freely, pauses in the stream only delay the next hit
	always_ff @(posedge clk) begin
		if (reset) begin
			window_done  <= 1'b0;
			capture      <= 1'b0;
			valid_out    <= 1'b0;
			load_weights <= 1'b0;
		end else begin
			window_done  <= valid_in && col_aligned && row_aligned;
			capture      <= window_done;
			valid_out    <= capture;
			load_weights <= capture && (state == WAIT_FIRST);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame tracking

	// Last window of a frame is long out before the frame's last pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WAIT_FIRST;
		end else if (valid_in && last_col && last_row) begin
			state <= WAIT_FIRST;
		end else if (capture) begin
			state <= STREAMING;
		end
	end

endmodule

// ==== testbench/conv_7x7_window_checker.sv ====
`timescale 1ns/1ps

module conv_7x7_window_checker (
	input logic                     clk,
	input logic                     reset,
	input logic                     valid_out,
	input logic                     load_weights,
	input conv_window_pkg::window_t pxl_window
);

	// Count of failed assertions
	int assert_failures = 0;

	////////////////////////////////////////////////////////////////////////////
	// Output protocol

	a_load_with_valid: assert property (
		@(posedge clk) disable iff (reset) load_weights |-> valid_out
	) else begin
		assert_failures++;
		$error("load_weights high without valid_out");
	end

	a_single_pulse: assert property (
		@(posedge clk) disable iff (reset) valid_out |=> !valid_out
	) else begin
		assert_failures++;
		$error("valid_out high on two consecutive cycles");
	end

	a_window_known: assert property (
		@(posedge clk) disable iff (reset) valid_out |-> !$isunknown(pxl_window)
	) else begin
		assert_failures++;
		$error("pxl_window has unknown bits while valid_out is high");
	end

	// Outputs are cleared by the first reset edge
	a_quiet_in_reset: assert property (
		@(posedge clk) (reset && $past(reset)) |-> (!valid_out && !load_weights)
	) else begin
		assert_failures++;
		$error("valid_out or load_weights high during reset");
	end

endmodule

bind conv_7x7_window conv_7x7_window_checker u_checker (
	.clk          (clk          ),
	.reset        (reset        ),
	.valid_out    (valid_out    ),
	.load_weights (load_weights ),
	.pxl_window   (pxl_window   )
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk
);

	// 100 ns period
	localparam int HALF_PERIOD = 50;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD;
			clk = ~clk;
		end
	end

endmodule

// ==== testbench/tb_conv_7x7_window.sv ====
`timescale 1ns/1ps
`include "conv_window_defines.svh"

module tb_conv_7x7_window;

	import conv_window_pkg::*;

	localparam int NUM_ENTRIES  = 6;
	localparam int PIXELS       = `CONV_IMAGE_WIDTH * `CONV_IMAGE_HEIGHT;
	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 1;
	localparam int DRAIN_LIMIT  = 16;
	localparam int LATENCY      = 2;
	localparam int WIN_COLS     = (`CONV_IMAGE_WIDTH - `CONV_KERNEL) / `CONV_STRIDE + 1;
	localparam int WIN_ROWS     = (`CONV_IMAGE_HEIGHT - `CONV_KERNEL) / `CONV_STRIDE + 1;
	localparam int WIN_PER_FRAME = WIN_COLS * WIN_ROWS;
	localparam longint WATCHDOG_NS = longint'(NUM_ENTRIES) * PIXELS * 4 * CLK_PERIOD +
		RESET_CYCLES * CLK_PERIOD;

	typedef enum {GAP_NONE, GAP_EVERY_THIRD, GAP_RANDOM} gap_mode_t;

	typedef struct {
		pixel_t    base;
		gap_mode_t gap;
		int        exp_windows;
		int        exp_loads;
	} frame_entry_t;

	logic    clk;
	logic    reset;
	logic    valid_in;
	pixel_t  pixel_in;
	window_t pxl_window;
	logic    valid_out;
	logic    load_weights;

	frame_entry_t stim [NUM_ENTRIES];
	integer       seed;
	int           errors = 0;
	int           cycle = 0;

	// Accept edge and frame of each pending completing pixel in order
	int accept_edges [$];
	int accept_frames [$];

	int frame_windows [NUM_ENTRIES];
	int frame_loads [NUM_ENTRIES];

	tb_clock_gen u_clock_gen (
		.clk (clk)
	);

	conv_7x7_window DUT (
		.clk          (clk          ),
		.reset        (reset        ),
		.valid_in     (valid_in     ),
		.pixel_in     (pixel_in     ),
		.pxl_window   (pxl_window   ),
		.valid_out    (valid_out    ),
		.load_weights (load_weights )
	);

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference rules

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("** Error at time %0t: %s: got %h, expected %h",
				$time, what, actual, expected);
			errors++;
		end
	endtask

	// Bottom-right pixel of a window on the stride grid
	function automatic bit completes_window(input int k);
		int row;
		int col;
		row = k / `CONV_IMAGE_WIDTH;
		col = k % `CONV_IMAGE_WIDTH;
		return (row >= `CONV_KERNEL - 1) && (col >= `CONV_KERNEL - 1) &&
			((row - (`CONV_KERNEL - 1)) % `CONV_STRIDE == 0) &&
			((col - (`CONV_KERNEL - 1)) % `CONV_STRIDE == 0);
	endfunction

	function automatic pixel_t expected_pixel(input pixel_t base, input int row, input int col);
		return base + pixel_t'(row * `CONV_IMAGE_WIDTH + col);
	endfunction

	// Window p of a frame with r outer and c inner
	task automatic compare_window(input int f, input int p);
		int r;
		int c;
		r = (p / WIN_COLS) * `CONV_STRIDE;
		c = (p % WIN_COLS) * `CONV_STRIDE;
		for (int i = 0; i < `CONV_KERNEL; i++) begin
			for (int j = 0; j < `CONV_KERNEL; j++) begin
				check_equal(pxl_window[i][j], expected_pixel(stim[f].base, r + i, c + j),
					$sformatf("frame %0d window (%0d,%0d) element (%0d,%0d)",
					f, r, c, i, j));
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic drive_idle();
		valid_in = 1'b0;
		// Junk data that the DUT ignores
		pixel_in = pixel_t'({$random(seed)});
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic drive_pixel(input int f, input int k);
		valid_in = 1'b1;
		pixel_in = stim[f].base + pixel_t'(k);
		if (completes_window(k)) begin
			accept_edges.push_back(cycle + 1);
			accept_frames.push_back(f);
		end
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic drive_frame(input int f);
		int idle;
		for (int k = 0; k < PIXELS; k++) begin
			case (stim[f].gap)
				GAP_EVERY_THIRD: idle = (k % 3 == 2) ? 1 : 0;
				GAP_RANDOM:      idle = {$random(seed)} % 3;
				default:         idle = 0;
			endcase
			repeat (idle) begin
				drive_idle();
			end
			drive_pixel(f, k);
		end
	endtask

	// All windows of the frame should be out by now
	task automatic wait_frame_drain(input int f);
		int waited;
		waited = 0;
		valid_in = 1'b0;
		while (accept_edges.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
		end
		if (accept_edges.size() != 0) begin
			$display("Frame %0d: %0d windows never appeared on the output",
				f, accept_edges.size());
			errors++;
			accept_edges.delete();
			accept_frames.delete();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor

	always @(negedge clk) begin : monitor
		int f;
		int p;
		int accepted;
		if (reset) begin
			if (valid_out !== 1'b0 || load_weights !== 1'b0) begin
				$display("Outputs not low during reset at time %0t", $time);
				errors++;
			end
		end else if (valid_out === 1'b1) begin
			if (accept_edges.size() == 0) begin
				$display("valid_out at time %0t with no completing pixel before it", $time);
				errors++;
			end else begin
				accepted = accept_edges.pop_front();
				f = accept_frames.pop_front();
				check_equal(cycle, accepted + LATENCY, "valid_out edge after completing pixel");
				p = frame_windows[f];
				frame_windows[f]++;
				if (load_weights === 1'b1) begin
					frame_loads[f]++;
				end
				check_equal(load_weights, (p == 0),
					$sformatf("frame %0d load_weights on window %0d", f, p));
				if (p < WIN_PER_FRAME) begin
					compare_window(f, p);
				end
			end
		end else if (valid_out !== 1'b0 || load_weights !== 1'b0) begin
			$display("valid_out unknown or load_weights alone at time %0t", $time);
			errors++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		seed = 32'h1ba7;
		reset = 1'b1;
		valid_in = 1'b0;
		pixel_in = '0;
		for (int f = 0; f < NUM_ENTRIES; f++) begin
			frame_windows[f] = 0;
			frame_loads[f] = 0;
		end

		// Base, gap mode, windows, load_weights pulses
		stim[0] = '{32'h0000_0000, GAP_NONE,        WIN_PER_FRAME, 1};
		stim[1] = '{32'h0001_0000, GAP_EVERY_THIRD, WIN_PER_FRAME, 1};
		stim[2] = '{32'h00a5_0300, GAP_RANDOM,      WIN_PER_FRAME, 1};
		stim[3] = '{32'hffff_ffc0, GAP_NONE,        WIN_PER_FRAME, 1};
		stim[4] = '{32'h1234_5600, GAP_RANDOM,      WIN_PER_FRAME, 1};
		stim[5] = '{32'h7fff_fff0, GAP_EVERY_THIRD, WIN_PER_FRAME, 1};

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		for (int f = 0; f < NUM_ENTRIES; f++) begin
			drive_frame(f);
			wait_frame_drain(f);
			check_equal(frame_windows[f], stim[f].exp_windows,
				$sformatf("frame %0d window count", f));
			check_equal(frame_loads[f], stim[f].exp_loads,
				$sformatf("frame %0d load_weights count", f));
		end

		$display("Result: %0d check errors, %0d assertion failures",
			errors, DUT.u_checker.assert_failures);
		if (errors == 0 && DUT.u_checker.assert_failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule
